//--- exu_pkg.sv
/*
 * Execute stage package
 * Shared widths, data types, op and branch-condition encodings
 * and the bypass select bit positions
 */

package exu_pkg;

   localparam int unsigned XLEN        = 32;  // Data word width
   localparam int unsigned GHR_SIZE    = 8;   // Global history length
   localparam int unsigned BYP_SRC_NUM = 4;   // Forwarding sources

   // Bit positions in a bypass select
   localparam int unsigned BYP_R_RESULT = 0;  // R-stage result
   localparam int unsigned BYP_LSU_M    = 1;  // Load result in M
   localparam int unsigned BYP_X_RESULT = 2;  // X-stage ALU result
   localparam int unsigned BYP_LSU_NB   = 3;  // Non-blocking load data

   localparam int unsigned PC_STEP = 4;       // Fall-through increment in bytes

   typedef logic [XLEN-1:0]        word_t;
   typedef logic [31:1]            pc_t;      // Halfword aligned
   typedef logic [GHR_SIZE-1:0]    ghr_t;
   typedef logic [BYP_SRC_NUM-1:0] byp_sel_t; // One-hot or zero

   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_OR    = 3'd3,
      ALU_XOR   = 3'd4,
      ALU_SLT   = 3'd5,
      ALU_SLTU  = 3'd6,
      ALU_PASSB = 3'd7
   } alu_op_t;

   typedef enum logic [2:0] {
      BR_NONE = 3'd0,  // Not a branch
      BR_EQ   = 3'd1,
      BR_NE   = 3'd2,
      BR_LT   = 3'd3,
      BR_GE   = 3'd4,
      BR_LTU  = 3'd5,
      BR_GEU  = 3'd6,
      BR_JAL  = 3'd7   // Always taken
   } br_cond_t;

endpackage

//--- exu_operand_sel.sv
/*
 * Operand select
 * One-hot bypass network and source muxing for the ALU operands
 * and the qualified LSU operands, all within the decode cycle
 */

`timescale 1ns/1ps

module exu_operand_sel (
   input  exu_pkg::byp_sel_t i_rs1_byp_sel,
   input  exu_pkg::byp_sel_t i_rs2_byp_sel,
   input  logic              i_rs1_en,
   input  logic              i_rs2_en,
   input  logic              i_select_pc_d,        // PC to rs1, for jal
   input  exu_pkg::word_t    i_gpr_rs1,
   input  exu_pkg::word_t    i_gpr_rs2,
   input  exu_pkg::word_t    i_immed,
   input  exu_pkg::pc_t      i_pc_d,
   input  exu_pkg::word_t    i_dec_result_r,
   input  exu_pkg::word_t    i_lsu_result_m,
   input  exu_pkg::word_t    i_lsu_nonblock_data,
   input  exu_pkg::word_t    i_x_result,           // Fed back from the ALU
   input  logic              i_qual_lsu_d,         // LSU instruction in decode
   output exu_pkg::word_t    o_rs1,
   output exu_pkg::word_t    o_rs2,
   output exu_pkg::word_t    o_lsu_rs1,
   output exu_pkg::word_t    o_lsu_rs2
);

   function automatic exu_pkg::word_t byp_mux(
      input exu_pkg::byp_sel_t sel,
      input exu_pkg::word_t    r_result,
      input exu_pkg::word_t    lsu_m,
      input exu_pkg::word_t    x_result,
      input exu_pkg::word_t    lsu_nb
   );
      // AND-OR mux, relies on the select being one-hot
      byp_mux = ({exu_pkg::XLEN{sel[exu_pkg::BYP_R_RESULT]}} & r_result) |
                ({exu_pkg::XLEN{sel[exu_pkg::BYP_LSU_M]}}    & lsu_m)    |
                ({exu_pkg::XLEN{sel[exu_pkg::BYP_X_RESULT]}} & x_result) |
                ({exu_pkg::XLEN{sel[exu_pkg::BYP_LSU_NB]}}   & lsu_nb);
   endfunction

   logic           rs1_byp_en, rs2_byp_en;
   exu_pkg::word_t rs1_byp, rs2_byp;
   exu_pkg::word_t rs1_reg, rs2_reg;   // Bypass or gpr, shared with LSU

   assign rs1_byp_en = |i_rs1_byp_sel;
   assign rs2_byp_en = |i_rs2_byp_sel;
   assign rs1_byp = byp_mux(i_rs1_byp_sel, i_dec_result_r, i_lsu_result_m,
                            i_x_result, i_lsu_nonblock_data);
   assign rs2_byp = byp_mux(i_rs2_byp_sel, i_dec_result_r, i_lsu_result_m,
                            i_x_result, i_lsu_nonblock_data);

   assign rs1_reg = rs1_byp_en ? rs1_byp : (i_rs1_en ? i_gpr_rs1 : '0);
   assign rs2_reg = rs2_byp_en ? rs2_byp : (i_rs2_en ? i_gpr_rs2 : '0);

   assign o_rs1 = (!rs1_byp_en && i_select_pc_d) ? {i_pc_d, 1'b0} : rs1_reg;
   assign o_rs2 = (rs2_byp_en || i_rs2_en) ? rs2_reg : i_immed;  // Immediate fallback

   assign o_lsu_rs1 = rs1_reg & {exu_pkg::XLEN{i_qual_lsu_d}};  // Quiet when no LSU op
   assign o_lsu_rs2 = rs2_reg & {exu_pkg::XLEN{i_qual_lsu_d}};

   always_comb begin
      assert ($onehot0(i_rs1_byp_sel) && $onehot0(i_rs2_byp_sel))
         else $error("Bypass select not one-hot: rs1 %b rs2 %b",
                     i_rs1_byp_sel, i_rs2_byp_sel);
   end

endmodule

//--- exu_alu.sv
/*
 * X-stage ALU
 * Captures operands, op and PC on the X strobe and computes the result
 * with one shared adder-subtractor that also gives the compare flags
 */

`timescale 1ns/1ps

module exu_alu (
   input  logic             clk,
   input  logic             i_reset,
   input  logic             i_x_en,
   input  exu_pkg::word_t   i_a,
   input  exu_pkg::word_t   i_b,
   input  exu_pkg::alu_op_t i_op,
   input  exu_pkg::pc_t     i_pc_d,
   output exu_pkg::word_t   o_result_x,
   output exu_pkg::pc_t     o_pc_x,
   output logic             o_eq,
   output logic             o_lt,   // Signed a < b
   output logic             o_ltu   // Unsigned a < b
);

   exu_pkg::word_t       a_x, b_x;
   exu_pkg::alu_op_t     op_x;
   exu_pkg::pc_t         pc_x;
   logic                 sub;
   exu_pkg::word_t       b_inv;
   logic [exu_pkg::XLEN:0] sum_ext;
   exu_pkg::word_t       sum;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         op_x <= exu_pkg::ALU_ADD;
      end else if (i_x_en) begin
         op_x <= i_op;
      end
   end

   always_ff @(posedge clk) begin
      if (i_x_en) begin
         a_x  <= i_a;
         b_x  <= i_b;
         pc_x <= i_pc_d;
      end
   end

   // Anything but add runs the adder as a - b, so compares see the difference
   assign sub     = (op_x != exu_pkg::ALU_ADD);
   assign b_inv   = sub ? ~b_x : b_x;
   assign sum_ext = {1'b0, a_x} + {1'b0, b_inv} + {{exu_pkg::XLEN{1'b0}}, sub};
   assign sum     = sum_ext[exu_pkg::XLEN-1:0];

   assign o_eq  = (sum == '0);
   assign o_ltu = ~sum_ext[exu_pkg::XLEN];                      // Borrow out
   assign o_lt  = (a_x[exu_pkg::XLEN-1] != b_x[exu_pkg::XLEN-1]) ?
                  a_x[exu_pkg::XLEN-1] : sum[exu_pkg::XLEN-1];  // Sign differs, a decides

   always_comb begin
      case (op_x)
         exu_pkg::ALU_ADD,
         exu_pkg::ALU_SUB:   o_result_x = sum;
         exu_pkg::ALU_AND:   o_result_x = a_x & b_x;
         exu_pkg::ALU_OR:    o_result_x = a_x | b_x;
         exu_pkg::ALU_XOR:   o_result_x = a_x ^ b_x;
         exu_pkg::ALU_SLT:   o_result_x = {{(exu_pkg::XLEN-1){1'b0}}, o_lt};
         exu_pkg::ALU_SLTU:  o_result_x = {{(exu_pkg::XLEN-1){1'b0}}, o_ltu};
         exu_pkg::ALU_PASSB: o_result_x = b_x;
         default:            o_result_x = sum;
      endcase
   end

   assign o_pc_x = pc_x;

endmodule

//--- exu_branch_resolve.sv
/*
 * X-stage branch resolution
 * Evaluates the branch condition, detects a mispredict against the
 * decode prediction and merges the X redirect with the trap flush
 */

`timescale 1ns/1ps

module exu_branch_resolve (
   input  logic              clk,
   input  logic              i_reset,
   input  logic              i_x_en,
   input  logic              i_alu_valid_d,
   input  exu_pkg::br_cond_t i_br_cond,
   input  logic [12:1]       i_br_immed,
   input  logic              i_pred_valid,
   input  logic              i_pred_taken,
   input  exu_pkg::pc_t      i_pc_x,
   input  logic              i_eq,
   input  logic              i_lt,
   input  logic              i_ltu,
   input  logic              i_tlu_flush_lower_r,   // Trap flush, wins over X
   input  exu_pkg::pc_t      i_tlu_flush_path_r,
   output logic              o_br_valid_x,
   output logic              o_taken_x,
   output logic              o_mispredict_x,
   output exu_pkg::pc_t      o_npc_x,
   output logic              o_flush_final,
   output exu_pkg::pc_t      o_flush_path_final
);

   exu_pkg::br_cond_t cond_x;
   logic [12:1]       brimm_x;
   logic              pred_taken_x;
   logic              valid_x;
   logic              cond_true;
   exu_pkg::pc_t      brimm_ext;
   logic              flush_upper_x;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         valid_x      <= 1'b0;
         cond_x       <= exu_pkg::BR_NONE;
         pred_taken_x <= 1'b0;
      end else begin
         valid_x <= i_x_en & i_alu_valid_d & ~i_tlu_flush_lower_r;  // One-cycle pulse
         if (i_x_en) begin
            cond_x       <= i_br_cond;
            pred_taken_x <= i_pred_valid & i_pred_taken;  // No prediction means not taken
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_x_en) begin
         brimm_x <= i_br_immed;
      end
   end

   always_comb begin
      case (cond_x)
         exu_pkg::BR_EQ:  cond_true = i_eq;
         exu_pkg::BR_NE:  cond_true = ~i_eq;
         exu_pkg::BR_LT:  cond_true = i_lt;
         exu_pkg::BR_GE:  cond_true = ~i_lt;
         exu_pkg::BR_LTU: cond_true = i_ltu;
         exu_pkg::BR_GEU: cond_true = ~i_ltu;
         exu_pkg::BR_JAL: cond_true = 1'b1;
         default:         cond_true = 1'b0;
      endcase
   end

   assign o_br_valid_x   = valid_x & (cond_x != exu_pkg::BR_NONE);
   assign o_taken_x      = o_br_valid_x & cond_true;
   assign o_mispredict_x = o_br_valid_x & (cond_true != pred_taken_x);

   assign brimm_ext = {{19{brimm_x[12]}}, brimm_x};
   assign o_npc_x   = cond_true ? (i_pc_x + brimm_ext) :
                      (i_pc_x + exu_pkg::pc_t'(exu_pkg::PC_STEP >> 1));  // Halfword units

   assign flush_upper_x      = o_mispredict_x & ~i_tlu_flush_lower_r;
   assign o_flush_final      = i_tlu_flush_lower_r | flush_upper_x;
   assign o_flush_path_final = i_tlu_flush_lower_r ? i_tlu_flush_path_r : o_npc_x;

   a_trap_flush_priority: assert property (@(posedge clk) disable iff (i_reset)
      i_tlu_flush_lower_r |-> (o_flush_final && (o_flush_path_final == i_tlu_flush_path_r)))
      else $error("X redirect overrode trap flush path");

endmodule

//--- exu_ghr.sv
/*
 * Global history registers
 * Decode-side history shifts in predictions, X-side history shifts in
 * resolved outcomes; decode restores from X on mispredict or trap flush
 */

`timescale 1ns/1ps

module exu_ghr (
   input  logic          clk,
   input  logic          i_reset,
   input  logic          i_x_en,
   input  logic          i_alu_valid_d,
   input  logic          i_pred_valid,
   input  logic          i_pred_taken,
   input  logic          i_br_valid_x,
   input  logic          i_taken_x,
   input  logic          i_mispredict_x,
   input  logic          i_tlu_flush_lower_r,
   output exu_pkg::ghr_t o_mp_fghr           // Decode restart history
);

   exu_pkg::ghr_t ghr_d, ghr_d_ns;
   exu_pkg::ghr_t ghr_x, ghr_x_ns;
   logic          pred_d;

   assign pred_d   = i_x_en & i_alu_valid_d & i_pred_valid;
   assign ghr_x_ns = i_br_valid_x ? {ghr_x[exu_pkg::GHR_SIZE-2:0], i_taken_x} : ghr_x;

   always_comb begin
      if (i_tlu_flush_lower_r) begin
         ghr_d_ns = ghr_x;                 // Trap, back to committed history
      end else if (i_mispredict_x) begin
         ghr_d_ns = ghr_x_ns;              // Includes the resolved branch
      end else if (pred_d) begin
         ghr_d_ns = {ghr_d[exu_pkg::GHR_SIZE-2:0], i_pred_taken};
      end else begin
         ghr_d_ns = ghr_d;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         ghr_d <= '0;
         ghr_x <= '0;
      end else begin
         ghr_d <= ghr_d_ns;
         ghr_x <= ghr_x_ns;
      end
   end

   assign o_mp_fghr = ghr_x_ns;

endmodule

//--- exu_branch_pipe.sv
/*
 * R-stage branch report
 * Captures the resolved X branch on the R strobe for the decoder
 */

`timescale 1ns/1ps

module exu_branch_pipe (
   input  logic         clk,
   input  logic         i_reset,
   input  logic         i_r_en,
   input  logic         i_br_valid_x,
   input  logic         i_mispredict_x,
   input  logic         i_taken_x,
   input  exu_pkg::pc_t i_npc_x,
   input  logic         i_tlu_flush_lower_r,
   output logic         o_br_valid_r,
   output logic         o_br_mp_r,
   output logic         o_br_taken_r,
   output exu_pkg::pc_t o_npc_r
);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_br_valid_r <= 1'b0;
         o_br_mp_r    <= 1'b0;
         o_br_taken_r <= 1'b0;
      end else begin
         if (i_tlu_flush_lower_r) begin
            o_br_valid_r <= 1'b0;           // Killed by trap
         end else if (i_r_en) begin
            o_br_valid_r <= i_br_valid_x;
         end
         if (i_r_en) begin
            o_br_mp_r    <= i_mispredict_x;
            o_br_taken_r <= i_taken_x;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_r_en) begin
         o_npc_r <= i_npc_x;
      end
   end

endmodule

//--- exu.sv
/*
 * Execute stage top
 * Operand select, X-stage ALU and branch resolution, global history
 * and the R-stage branch report
 */

`timescale 1ns/1ps

module exu (
   input  logic              clk,
   input  logic              i_reset,
   input  logic              i_x_en,               // Capture decode into X
   input  logic              i_r_en,               // Capture X into R
   input  exu_pkg::byp_sel_t i_rs1_byp_sel,
   input  exu_pkg::byp_sel_t i_rs2_byp_sel,
   input  logic              i_rs1_en,
   input  logic              i_rs2_en,
   input  logic              i_select_pc_d,
   input  exu_pkg::word_t    i_gpr_rs1,
   input  exu_pkg::word_t    i_gpr_rs2,
   input  exu_pkg::word_t    i_immed,
   input  exu_pkg::pc_t      i_pc_d,
   input  exu_pkg::word_t    i_dec_result_r,
   input  exu_pkg::word_t    i_lsu_result_m,
   input  exu_pkg::word_t    i_lsu_nonblock_data,
   input  logic              i_alu_valid_d,
   input  exu_pkg::alu_op_t  i_alu_op,
   input  exu_pkg::br_cond_t i_br_cond,
   input  logic [12:1]       i_br_immed,
   input  logic              i_pred_valid,
   input  logic              i_pred_taken,
   input  logic              i_qual_lsu_d,
   input  logic              i_tlu_flush_lower_r,
   input  exu_pkg::pc_t      i_tlu_flush_path_r,
   output exu_pkg::word_t    o_lsu_rs1_d,
   output exu_pkg::word_t    o_lsu_rs2_d,
   output exu_pkg::word_t    o_i0_result_x,
   output exu_pkg::pc_t      o_i0_pc_x,
   output logic              o_flush_final,
   output exu_pkg::pc_t      o_flush_path_final,
   output logic              o_br_valid_r,
   output logic              o_br_mp_r,
   output logic              o_br_taken_r,
   output exu_pkg::pc_t      o_npc_r,
   output exu_pkg::ghr_t     o_mp_fghr
);

   exu_pkg::word_t rs1_d, rs2_d;
   logic           eq_x, lt_x, ltu_x;
   logic           br_valid_x, taken_x, mispredict_x;
   exu_pkg::pc_t   npc_x;

   exu_operand_sel u_operand_sel (
      .i_rs1_byp_sel(i_rs1_byp_sel), .i_rs2_byp_sel(i_rs2_byp_sel),
      .i_rs1_en(i_rs1_en), .i_rs2_en(i_rs2_en), .i_select_pc_d(i_select_pc_d),
      .i_gpr_rs1(i_gpr_rs1), .i_gpr_rs2(i_gpr_rs2), .i_immed(i_immed), .i_pc_d(i_pc_d),
      .i_dec_result_r(i_dec_result_r), .i_lsu_result_m(i_lsu_result_m),
      .i_lsu_nonblock_data(i_lsu_nonblock_data), .i_x_result(o_i0_result_x),
      .i_qual_lsu_d(i_qual_lsu_d), .o_rs1(rs1_d), .o_rs2(rs2_d),
      .o_lsu_rs1(o_lsu_rs1_d), .o_lsu_rs2(o_lsu_rs2_d));

   exu_alu u_alu (
      .clk(clk), .i_reset(i_reset), .i_x_en(i_x_en), .i_a(rs1_d), .i_b(rs2_d),
      .i_op(i_alu_op), .i_pc_d(i_pc_d), .o_result_x(o_i0_result_x), .o_pc_x(o_i0_pc_x),
      .o_eq(eq_x), .o_lt(lt_x), .o_ltu(ltu_x));

   exu_branch_resolve u_branch_resolve (
      .clk(clk), .i_reset(i_reset), .i_x_en(i_x_en), .i_alu_valid_d(i_alu_valid_d),
      .i_br_cond(i_br_cond), .i_br_immed(i_br_immed), .i_pred_valid(i_pred_valid),
      .i_pred_taken(i_pred_taken), .i_pc_x(o_i0_pc_x), .i_eq(eq_x), .i_lt(lt_x),
      .i_ltu(ltu_x), .i_tlu_flush_lower_r(i_tlu_flush_lower_r),
      .i_tlu_flush_path_r(i_tlu_flush_path_r), .o_br_valid_x(br_valid_x),
      .o_taken_x(taken_x), .o_mispredict_x(mispredict_x), .o_npc_x(npc_x),
      .o_flush_final(o_flush_final), .o_flush_path_final(o_flush_path_final));

   exu_ghr u_ghr (
      .clk(clk), .i_reset(i_reset), .i_x_en(i_x_en), .i_alu_valid_d(i_alu_valid_d),
      .i_pred_valid(i_pred_valid), .i_pred_taken(i_pred_taken),
      .i_br_valid_x(br_valid_x), .i_taken_x(taken_x), .i_mispredict_x(mispredict_x),
      .i_tlu_flush_lower_r(i_tlu_flush_lower_r), .o_mp_fghr(o_mp_fghr));

   exu_branch_pipe u_branch_pipe (
      .clk(clk), .i_reset(i_reset), .i_r_en(i_r_en), .i_br_valid_x(br_valid_x),
      .i_mispredict_x(mispredict_x), .i_taken_x(taken_x), .i_npc_x(npc_x),
      .i_tlu_flush_lower_r(i_tlu_flush_lower_r), .o_br_valid_r(o_br_valid_r),
      .o_br_mp_r(o_br_mp_r), .o_br_taken_r(o_br_taken_r), .o_npc_r(o_npc_r));

endmodule

//--- tb_exu.sv
/*
 * Execute stage testbench
 * Directed tests of the ALU, bypass network, branch resolution,
 * trap flush priority, R-stage branch report and global history
 */

`timescale 1ns/1ps

module tb_exu;

   localparam int CLK_PERIOD  = 10;
   localparam int RUN_CYCLES  = 10 + 16 + 6 + (42 + 20 + 2) * 2;  // Reset, ALU, bypass, branches
   localparam int WATCHDOG_NS = (RUN_CYCLES + 50) * CLK_PERIOD;

   logic clk, i_reset, i_x_en, i_r_en;
   exu_pkg::byp_sel_t i_rs1_byp_sel, i_rs2_byp_sel;
   logic i_rs1_en, i_rs2_en, i_select_pc_d;
   exu_pkg::word_t i_gpr_rs1, i_gpr_rs2, i_immed;
   exu_pkg::pc_t i_pc_d, i_tlu_flush_path_r;
   exu_pkg::word_t i_dec_result_r, i_lsu_result_m, i_lsu_nonblock_data;
   logic i_alu_valid_d, i_pred_valid, i_pred_taken, i_qual_lsu_d, i_tlu_flush_lower_r;
   exu_pkg::alu_op_t i_alu_op;
   exu_pkg::br_cond_t i_br_cond;
   logic [12:1] i_br_immed;
   exu_pkg::word_t o_lsu_rs1_d, o_lsu_rs2_d, o_i0_result_x;
   exu_pkg::pc_t o_i0_pc_x, o_flush_path_final, o_npc_r;
   logic o_flush_final, o_br_valid_r, o_br_mp_r, o_br_taken_r;
   exu_pkg::ghr_t o_mp_fghr;

   int unsigned errors, checks;
   logic [31:0] seed;
   exu_pkg::word_t last_result;  // Expected X result for the bypass
   exu_pkg::ghr_t ghr_model;     // Shift of resolved outcomes

   exu dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic exu_pkg::word_t alu_model(input exu_pkg::alu_op_t op,
                                                input exu_pkg::word_t a, b);
      case (op)
         exu_pkg::ALU_ADD:  return a + b;
         exu_pkg::ALU_SUB:  return a - b;
         exu_pkg::ALU_AND:  return a & b;
         exu_pkg::ALU_OR:   return a | b;
         exu_pkg::ALU_XOR:  return a ^ b;
         exu_pkg::ALU_SLT:  return 32'($signed(a) < $signed(b));
         exu_pkg::ALU_SLTU: return 32'(a < b);
         default:           return b;  // Pass-b
      endcase
   endfunction

   function automatic logic cond_holds(input exu_pkg::br_cond_t cond,
                                       input exu_pkg::word_t a, b);
      case (cond)
         exu_pkg::BR_EQ:  return a == b;
         exu_pkg::BR_NE:  return a != b;
         exu_pkg::BR_LT:  return $signed(a) < $signed(b);
         exu_pkg::BR_GE:  return $signed(a) >= $signed(b);
         exu_pkg::BR_LTU: return a < b;
         exu_pkg::BR_GEU: return a >= b;
         exu_pkg::BR_JAL: return 1'b1;
         default:         return 1'b0;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   // Edge that captures decode into X
   task automatic clock_capture();
      tick();
      i_x_en        = 1'b0;
      i_alu_valid_d = 1'b0;
   endtask

   task automatic drive_idle();
      {i_x_en, i_r_en, i_rs1_en, i_rs2_en, i_select_pc_d} = '0;
      {i_rs1_byp_sel, i_rs2_byp_sel} = '0;
      {i_gpr_rs1, i_gpr_rs2, i_immed, i_pc_d, i_tlu_flush_path_r} = '0;
      {i_dec_result_r, i_lsu_result_m, i_lsu_nonblock_data, i_br_immed} = '0;
      {i_alu_valid_d, i_pred_valid, i_pred_taken, i_qual_lsu_d, i_tlu_flush_lower_r} = '0;
      i_alu_op  = exu_pkg::ALU_ADD;
      i_br_cond = exu_pkg::BR_NONE;
   endtask

   task automatic alu_ops();
      exu_pkg::word_t a, b;
      logic [31:0] r;
      for (int k = 0; k < 8; k++) begin
         for (int pass = 0; pass < 2; pass++) begin
            a = next_rand();
            b = (pass == 0) ? next_rand() : a ^ 32'h8000_0000;  // Second pass flips the sign
            r = next_rand();
            {i_gpr_rs1, i_gpr_rs2, i_rs1_en, i_rs2_en} = {a, b, 2'b11};
            i_alu_op = exu_pkg::alu_op_t'(k[2:0]);
            i_pc_d   = r[31:1];
            i_x_en   = 1'b1;
            clock_capture();
            last_result = alu_model(exu_pkg::alu_op_t'(k[2:0]), a, b);
            check_val("o_i0_result_x", last_result, o_i0_result_x);
            check_val("o_i0_pc_x", {r[31:1], 1'b0}, {o_i0_pc_x, 1'b0});
         end
      end
   endtask

   task automatic bypass_sources();
      exu_pkg::word_t src [exu_pkg::BYP_SRC_NUM];
      exu_pkg::word_t gpr;
      logic [31:0] r;
      int j;
      for (int k = 0; k < exu_pkg::BYP_SRC_NUM; k++) begin
         j = (k + 1) % exu_pkg::BYP_SRC_NUM;   // rs2 takes the next source
         src[exu_pkg::BYP_R_RESULT] = next_rand();
         src[exu_pkg::BYP_LSU_M]    = next_rand();
         src[exu_pkg::BYP_LSU_NB]   = next_rand();
         src[exu_pkg::BYP_X_RESULT] = last_result;
         i_dec_result_r      = src[exu_pkg::BYP_R_RESULT];
         i_lsu_result_m      = src[exu_pkg::BYP_LSU_M];
         i_lsu_nonblock_data = src[exu_pkg::BYP_LSU_NB];
         {i_gpr_rs1, i_gpr_rs2, i_rs1_en, i_rs2_en} = {next_rand(), next_rand(), 2'b11};
         i_rs1_byp_sel = 4'b0001 << k;
         i_rs2_byp_sel = 4'b0001 << j;
         i_qual_lsu_d  = ~k[0];                 // Odd passes leave the LSU unqualified
         i_alu_op      = exu_pkg::ALU_ADD;
         i_x_en        = 1'b1;
         #1;
         check_val("o_lsu_rs1_d", k[0] ? '0 : src[k], o_lsu_rs1_d);
         check_val("o_lsu_rs2_d", k[0] ? '0 : src[j], o_lsu_rs2_d);
         clock_capture();
         last_result = src[k] + src[j];
         check_val("o_i0_result_x", last_result, o_i0_result_x);
      end
      // PC onto rs1 and immediate onto rs2
      gpr = next_rand();
      r   = next_rand();
      i_rs1_byp_sel = '0;
      i_rs2_byp_sel = '0;
      i_select_pc_d = 1'b1;
      i_rs1_en      = 1'b1;
      i_rs2_en      = 1'b0;
      {i_gpr_rs1, i_immed, i_pc_d, i_qual_lsu_d, i_x_en} = {gpr, next_rand(), r[31:1], 2'b11};
      #1;
      check_val("o_lsu_rs1_d", gpr, o_lsu_rs1_d);
      check_val("o_lsu_rs2_d", '0, o_lsu_rs2_d);
      clock_capture();
      last_result = {r[31:1], 1'b0} + i_immed;
      check_val("o_i0_result_x", last_result, o_i0_result_x);
      {i_select_pc_d, i_rs1_en, i_immed, i_x_en} = {2'b00, next_rand(), 1'b1};
      i_alu_op = exu_pkg::ALU_PASSB;
      clock_capture();
      last_result = i_immed;
      check_val("o_i0_result_x", last_result, o_i0_result_x);
   endtask

   // One branch through X and R with an optional trap flush in X
   task automatic run_branch(input exu_pkg::br_cond_t cond, input exu_pkg::word_t a, b,
                             input logic pv, input logic pt, input logic trap);
      logic [31:0] r, npc;
      logic [12:1] imm;
      logic taken, mp;
      r     = next_rand();
      imm   = r[11:0];
      taken = cond_holds(cond, a, b);
      mp    = taken != (pv & pt);
      npc   = taken ? {r[31:1], 1'b0} + {{19{imm[12]}}, imm, 1'b0} :
                      {r[31:1], 1'b0} + exu_pkg::PC_STEP;
      ghr_model = {ghr_model[exu_pkg::GHR_SIZE-2:0], taken};
      {i_gpr_rs1, i_gpr_rs2, i_rs1_en, i_rs2_en} = {a, b, 2'b11};
      {i_rs1_byp_sel, i_rs2_byp_sel, i_select_pc_d} = '0;
      i_alu_op   = exu_pkg::ALU_SUB;
      i_br_cond  = cond;
      i_br_immed = imm;
      {i_pc_d, i_pred_valid, i_pred_taken, i_alu_valid_d, i_x_en} = {r[31:1], pv, pt, 2'b11};
      clock_capture();
      r = next_rand();
      {i_r_en, i_tlu_flush_lower_r, i_tlu_flush_path_r} = {1'b1, trap, r[31:1]};
      #1;
      check_val("o_flush_final", 32'(trap | mp), 32'(o_flush_final));
      if (trap) begin
         check_val("o_flush_path_final", {r[31:1], 1'b0}, {o_flush_path_final, 1'b0});
      end else if (mp) begin
         check_val("o_flush_path_final", npc, {o_flush_path_final, 1'b0});
      end
      check_val("o_mp_fghr", 32'(ghr_model), 32'(o_mp_fghr));
      tick();
      {i_r_en, i_tlu_flush_lower_r} = 2'b00;
      check_val("o_br_valid_r", 32'(!trap), 32'(o_br_valid_r));
      if (!trap) begin
         check_val("o_flush_final", '0, 32'(o_flush_final));  // One cycle only
         check_val("o_br_mp_r", 32'(mp), 32'(o_br_mp_r));
         check_val("o_br_taken_r", 32'(taken), 32'(o_br_taken_r));
         check_val("o_npc_r", npc, {o_npc_r, 1'b0});
      end
      check_val("o_mp_fghr", 32'(ghr_model), 32'(o_mp_fghr));
   endtask

   task automatic branch_conditions();
      exu_pkg::word_t s, n;
      exu_pkg::br_cond_t cond;
      logic t;
      for (int c = 1; c < 8; c++) begin
         cond = exu_pkg::br_cond_t'(c[2:0]);
         for (int k = 0; k < 2; k++) begin
            s = next_rand() & 32'h3fff_ffff;  // Small positive
            n = ~s;                           // Negative and large unsigned
            t = (k == 0);                     // Operands meant to make the condition true
            for (int p = 0; p < 3; p++) begin
               case (cond)
                  exu_pkg::BR_EQ:  run_branch(cond, s, t ? s : n, p != 2, p != 0, 1'b0);
                  exu_pkg::BR_NE:  run_branch(cond, s, t ? n : s, p != 2, p != 0, 1'b0);
                  exu_pkg::BR_LT,
                  exu_pkg::BR_GEU: run_branch(cond, t ? n : s, t ? s : n, p != 2, p != 0, 1'b0);
                  default:         run_branch(cond, t ? s : n, t ? n : s, p != 2, p != 0, 1'b0);
               endcase
            end
         end
      end
   endtask

   task automatic history_sequence();
      logic [9:0] pattern;
      exu_pkg::word_t s;
      pattern = 10'b1101001110;
      for (int k = 0; k < 10; k++) begin
         s = next_rand();
         run_branch(exu_pkg::BR_EQ, s, pattern[k] ? s : ~s, 1'b1, pattern[k], 1'b0);
      end
   endtask

   task automatic trap_priority();
      run_branch(exu_pkg::BR_EQ, 32'h55, 32'h55, 1'b1, 1'b0, 1'b1);  // Mispredicted under trap
      run_branch(exu_pkg::BR_NE, 32'h55, 32'h55, 1'b0, 1'b0, 1'b1);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      clk         = 1'b0;
      errors      = 0;
      checks      = 0;
      seed        = 32'h66fc;
      ghr_model   = '0;
      last_result = '0;
      drive_idle();
      i_reset = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      i_reset = 1'b0;
      check_val("o_mp_fghr", '0, 32'(o_mp_fghr));
      check_val("o_br_valid_r", '0, 32'(o_br_valid_r));
      check_val("o_flush_final", '0, 32'(o_flush_final));
      alu_ops();
      bypass_sources();
      branch_conditions();
      history_sequence();
      trap_priority();
      history_sequence();  // Continues from the history left by the trap
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
exu_pkg.sv
exu_operand_sel.sv
exu_alu.sv
exu_branch_resolve.sv
exu_ghr.sv
exu_branch_pipe.sv
exu.sv
tb_exu.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exu
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= STATUS: PASS

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Fails unless the pass message is printed
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
